//--- controlEncoder.sv
`timescale 1ns/1ps

module controlEncoder (
	input  controlPkg::ctrlState                          state,
	input  controlPkg::aluOp                              aluSel,
	input  controlPkg::excCause                           cause,
	input  logic [controlPkg::OpcodeWidth-1:0]            opcode,
	output logic [controlPkg::MuxAWidth-1:0]              muxA,
	output logic [controlPkg::MuxBWidth-1:0]              muxB,
	output logic [controlPkg::MuxAluWidth-1:0]            muxAlu,
	output logic [controlPkg::MuxPcWidth-1:0]             muxPc,
	output logic [controlPkg::MuxZeroWidth-1:0]           muxZero,
	output logic [controlPkg::MuxRegDestWidth-1:0]        muxRegDest,
	output logic [controlPkg::MuxWriteDataWidth-1:0]      muxWriteData,
	output controlPkg::aluOp                              aluControl,
	output logic                                          memWrite,
	output logic                                          loadRegAlu,
	output logic                                          loadRegA,
	output logic                                          loadRegB,
	output logic                                          loadRegMemData,
	output logic                                          loadRegEpc,
	output logic                                          irWrite,
	output logic                                          pcWrite,
	output logic                                          pcWriteCond,
	output logic                                          regWrite
);
	import controlPkg::*;

	logic [MuxPcWidth-1:0]   excVector;
	logic [MuxZeroWidth-1:0] zeroSel;

	assign excVector = (cause == CauseOverflow) ? 3'd3 : 3'd2; // Overflow or opcode handler
	assign zeroSel = (opcode == OpBne) ? 2'd1 : 2'd0; // BNE inverts the zero flag

	always_comb begin
		muxA = '0;
		muxB = '0;
		muxAlu = '0;
		muxPc = '0;
		muxZero = '0;
		muxRegDest = '0;
		muxWriteData = '0;
		aluControl = AluNone;
		memWrite = 1'b0;
		loadRegAlu = 1'b0;
		loadRegA = 1'b0;
		loadRegB = 1'b0;
		loadRegMemData = 1'b0;
		loadRegEpc = 1'b0;
		irWrite = 1'b0;
		pcWrite = 1'b0;
		pcWriteCond = 1'b0;
		regWrite = 1'b0;
		case (state)
			Fetch: begin
				muxB = 2'd1; // Constant 4
				aluControl = AluAdd;
			end
			FetchWait: irWrite = 1'b1;
			Decode: begin
				muxB = 2'd1;
				loadRegA = 1'b1;
				loadRegB = 1'b1;
				irWrite = 1'b1;
				pcWrite = 1'b1;
				aluControl = AluAdd;
			end
			Arith1, Arith2, Arith3: begin
				muxA = 2'd1;
				muxRegDest = 2'd1; // rd field
				loadRegAlu = 1'b1;
				loadRegA = (state != Arith2);
				loadRegB = (state != Arith2);
				regWrite = (state == Arith3);
				aluControl = aluSel;
			end
			ArithImm1, ArithImm2, ArithImm3: begin
				muxA = 2'd1;
				muxB = 2'd2; // Sign-extended immediate
				loadRegAlu = 1'b1;
				loadRegA = (state != ArithImm2);
				loadRegB = (state != ArithImm2);
				regWrite = (state == ArithImm3);
				aluControl = aluSel;
			end
			Branch1: begin
				muxB = 2'd3; // Shifted offset
				muxZero = zeroSel;
				loadRegAlu = 1'b1;
				loadRegA = 1'b1;
				loadRegB = 1'b1;
				aluControl = AluAdd;
			end
			Branch2: begin
				muxA = 2'd1;
				muxAlu = 3'd1;
				muxZero = zeroSel;
				loadRegA = 1'b1;
				loadRegB = 1'b1;
				pcWriteCond = 1'b1;
				aluControl = AluSub; // Compare rs and rt
			end
			Load1, Load2, LoadWait, Load3, Load4: begin
				muxA = 2'd1;
				muxB = 2'd2;
				muxPc = 3'd1; // Address from ALU out
				loadRegAlu = (state == Load1);
				loadRegA = (state == Load1 || state == Load2 || state == LoadWait);
				loadRegMemData = (state == Load3);
				muxWriteData = (state == Load3 || state == Load4) ? 4'd1 : 4'd0;
				regWrite = (state == Load4);
				aluControl = (state == Load1) ? AluAdd : AluNone;
			end
			Store1, Store2, Store3: begin
				muxA = 2'd1;
				muxB = 2'd2;
				muxPc = 3'd1;
				loadRegAlu = (state == Store1);
				loadRegA = 1'b1;
				loadRegB = (state == Store1);
				memWrite = (state == Store3);
				aluControl = AluAdd;
			end
			Jal: begin
				muxAlu = 3'd2;
				muxRegDest = 2'd2; // Return address register
				muxWriteData = 4'd5;
				regWrite = 1'b1;
			end
			Jump: begin
				muxAlu = 3'd2;
				pcWrite = 1'b1;
			end
			JumpReg: begin
				muxAlu = 3'd3;
				pcWrite = 1'b1;
			end
			Exc1, Exc2, Exc3: begin
				muxB = 2'd1;
				muxAlu = 3'd5;
				muxPc = excVector;
				loadRegEpc = (state == Exc1); // Saves PC minus 4
				pcWrite = (state != Exc1);
				aluControl = (state == Exc1) ? AluSub : AluNone;
			end
			ResetSt: begin
				muxRegDest = 2'd3;
				muxWriteData = 4'd11; // Zero source clears the register file
				regWrite = 1'b1;
			end
			default: ; // Idle and Break drive nothing
		endcase
	end

	always_comb begin
		assert (!(memWrite && regWrite))
			else $error("memory and register writes together in %s", state.name());
	end

endmodule

//--- controlPkg.sv
package controlPkg;

	localparam int OpcodeWidth = 6;
	localparam int FunctWidth = 6;
	localparam int InstrLowWidth = 26;

	// Datapath select widths
	localparam int MuxAWidth = 2;
	localparam int MuxBWidth = 2;
	localparam int MuxAluWidth = 3;
	localparam int MuxPcWidth = 3;
	localparam int MuxZeroWidth = 2;
	localparam int MuxRegDestWidth = 2;
	localparam int MuxWriteDataWidth = 4;

	typedef enum logic [4:0] {
		Idle, Fetch, FetchWait, Decode,
		Arith1, Arith2, Arith3,
		ArithImm1, ArithImm2, ArithImm3,
		Branch1, Branch2,
		Load1, Load2, LoadWait, Load3, Load4,
		Store1, Store2, Store3,
		Jal, Jump, JumpReg, Break,
		Exc1, Exc2, Exc3,
		ResetSt
	} ctrlState;

	typedef enum logic [3:0] {
		ClsNop, ClsArith, ClsArithImm, ClsBeq, ClsBne, ClsLoad,
		ClsStore, ClsJump, ClsJal, ClsJumpReg, ClsBreak, ClsInvalid
	} instrClass;

	typedef enum logic [2:0] {
		AluNone = 3'd0,
		AluAdd = 3'd1,
		AluSub = 3'd2,
		AluAnd = 3'd3,
		AluUndef = 3'd7
	} aluOp;

	typedef enum logic {
		CauseOpcode,
		CauseOverflow
	} excCause;

	localparam logic [OpcodeWidth-1:0] OpRType = 6'h00;
	localparam logic [OpcodeWidth-1:0] OpJump = 6'h02;
	localparam logic [OpcodeWidth-1:0] OpJal = 6'h03;
	localparam logic [OpcodeWidth-1:0] OpBeq = 6'h04;
	localparam logic [OpcodeWidth-1:0] OpBne = 6'h05;
	localparam logic [OpcodeWidth-1:0] OpAddi = 6'h08;
	localparam logic [OpcodeWidth-1:0] OpAddiu = 6'h09;
	localparam logic [OpcodeWidth-1:0] OpLw = 6'h23;
	localparam logic [OpcodeWidth-1:0] OpSw = 6'h2b;

	localparam logic [FunctWidth-1:0] FnBreak = 6'h0d;
	localparam logic [FunctWidth-1:0] FnJr = 6'h08;
	localparam logic [FunctWidth-1:0] FnAdd = 6'h20;
	localparam logic [FunctWidth-1:0] FnSub = 6'h22;
	localparam logic [FunctWidth-1:0] FnAnd = 6'h24;

endpackage

//--- controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input  logic                                     Clk,
	input  logic                                     Reset,
	input  logic [controlPkg::OpcodeWidth-1:0]       opcode,
	input  logic [controlPkg::FunctWidth-1:0]        funct,
	input  logic [controlPkg::InstrLowWidth-1:0]     instrLow,
	input  logic                                     overflow,
	output logic [controlPkg::MuxAWidth-1:0]         muxA,
	output logic [controlPkg::MuxBWidth-1:0]         muxB,
	output logic [controlPkg::MuxAluWidth-1:0]       muxAlu,
	output logic [controlPkg::MuxPcWidth-1:0]        muxPc,
	output logic [controlPkg::MuxZeroWidth-1:0]      muxZero,
	output logic [controlPkg::MuxRegDestWidth-1:0]   muxRegDest,
	output logic [controlPkg::MuxWriteDataWidth-1:0] muxWriteData,
	output controlPkg::aluOp                         aluControl,
	output logic                                     memWrite,
	output logic                                     loadRegAlu,
	output logic                                     loadRegA,
	output logic                                     loadRegB,
	output logic                                     loadRegMemData,
	output logic                                     loadRegEpc,
	output logic                                     irWrite,
	output logic                                     pcWrite,
	output logic                                     pcWriteCond,
	output logic                                     regWrite,
	output controlPkg::ctrlState                     state
);
	import controlPkg::*;

	instrClass cls;
	aluOp      aluSel;
	logic      trapOverflow;
	excCause   cause;

	instrDecoder instrDecoder_i (
		.opcode       (opcode),
		.funct        (funct),
		.instrLow     (instrLow),
		.cls          (cls),
		.aluSel       (aluSel),
		.trapOverflow (trapOverflow)
	);

	stateSequencer stateSequencer_i (
		.Clk          (Clk),
		.Reset        (Reset),
		.cls          (cls),
		.trapOverflow (trapOverflow),
		.overflow     (overflow),
		.state        (state),
		.cause        (cause)
	);

	controlEncoder controlEncoder_i (
		.state          (state),
		.aluSel         (aluSel),
		.cause          (cause),
		.opcode         (opcode),
		.muxA           (muxA),
		.muxB           (muxB),
		.muxAlu         (muxAlu),
		.muxPc          (muxPc),
		.muxZero        (muxZero),
		.muxRegDest     (muxRegDest),
		.muxWriteData   (muxWriteData),
		.aluControl     (aluControl),
		.memWrite       (memWrite),
		.loadRegAlu     (loadRegAlu),
		.loadRegA       (loadRegA),
		.loadRegB       (loadRegB),
		.loadRegMemData (loadRegMemData),
		.loadRegEpc     (loadRegEpc),
		.irWrite        (irWrite),
		.pcWrite        (pcWrite),
		.pcWriteCond    (pcWriteCond),
		.regWrite       (regWrite)
	);

endmodule

//--- controlModel.svh
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// Included inside a module that imports controlPkg

typedef struct packed {
	logic       regWrite;
	logic       memWrite;
	logic       pcWrite;
	logic       pcWriteCond;
	logic       loadRegEpc;
	logic [2:0] muxPc;
	aluOp       aluControl;
} modelOutputs;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	return y ^ (y << 5);
endfunction

// trapOvf is overflow already qualified by the instruction
function automatic ctrlState modelNext(input ctrlState st, input instrClass cls,
		input logic trapOvf);
	case (st)
		Idle:      return Fetch;
		Fetch:     return FetchWait;
		FetchWait: return Decode;
		Decode: begin
			case (cls)
				ClsNop:            return Idle;
				ClsArith:          return Arith1;
				ClsArithImm:       return ArithImm1;
				ClsBeq, ClsBne:    return Branch1;
				ClsLoad:           return Load1;
				ClsStore:          return Store1;
				ClsJump:           return Jump;
				ClsJal:            return Jal;
				ClsJumpReg:        return JumpReg;
				ClsBreak:          return Break;
				default:           return Exc1;
			endcase
		end
		Arith1:    return Arith2;
		Arith2:    return trapOvf ? Exc1 : Arith3;
		ArithImm1: return ArithImm2;
		ArithImm2: return trapOvf ? Exc1 : ArithImm3;
		Branch1:   return Branch2;
		Load1:     return Load2;
		Load2:     return LoadWait;
		LoadWait:  return Load3;
		Load3:     return Load4;
		Store1:    return Store2;
		Store2:    return Store3;
		Jal:       return Jump;
		Break:     return Break;
		Exc1:      return Exc2;
		Exc2:      return Exc3;
		default:   return Idle;
	endcase
endfunction

function automatic excCause modelCause(input ctrlState st, input instrClass cls,
		input logic trapOvf, input excCause cause);
	if ((st == Arith2 || st == ArithImm2) && trapOvf)
		return CauseOverflow;
	if (st == Decode && cls == ClsInvalid)
		return CauseOpcode;
	return cause;
endfunction

function automatic modelOutputs modelExpect(input ctrlState st, input aluOp aluSel,
		input excCause cause);
	modelOutputs o;
	o = '0;
	o.aluControl = AluNone;
	o.regWrite = st inside {Arith3, ArithImm3, Load4, Jal, ResetSt};
	o.memWrite = (st == Store3);
	o.pcWrite = st inside {Decode, Jump, JumpReg, Exc2, Exc3};
	o.pcWriteCond = (st == Branch2);
	o.loadRegEpc = (st == Exc1);
	if (st inside {Load1, Load2, LoadWait, Load3, Load4, Store1, Store2, Store3})
		o.muxPc = 3'd1;
	else if (st inside {Exc1, Exc2, Exc3})
		o.muxPc = (cause == CauseOverflow) ? 3'd3 : 3'd2;
	if (st inside {Fetch, Decode, Branch1, Load1, Store1, Store2, Store3})
		o.aluControl = AluAdd;
	else if (st inside {Arith1, Arith2, Arith3, ArithImm1, ArithImm2, ArithImm3})
		o.aluControl = aluSel;
	else if (st == Branch2 || st == Exc1)
		o.aluControl = AluSub;
	return o;
endfunction

`endif

//--- controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;
	import controlPkg::*;
	`include "controlModel.svh"

	localparam int IdleTimeout = 20;
	localparam int BreakHold = 10;

	// Instruction kinds picked by the stimulus
	localparam int KAdd = 0;
	localparam int KSub = 1;
	localparam int KAnd = 2;
	localparam int KAddi = 3;
	localparam int KAddiu = 4;
	localparam int KBeq = 5;
	localparam int KBne = 6;
	localparam int KLw = 7;
	localparam int KSw = 8;
	localparam int KJ = 9;
	localparam int KJal = 10;
	localparam int KJr = 11;
	localparam int KNop = 12;
	localparam int KBreak = 13;
	localparam int KInvalid = 14;

	logic                         Clk;
	logic                         Reset;
	logic [OpcodeWidth-1:0]       opcode;
	logic [FunctWidth-1:0]        funct;
	logic [InstrLowWidth-1:0]     instrLow;
	logic                         overflow;
	logic [MuxAWidth-1:0]         muxA;
	logic [MuxBWidth-1:0]         muxB;
	logic [MuxAluWidth-1:0]       muxAlu;
	logic [MuxPcWidth-1:0]        muxPc;
	logic [MuxZeroWidth-1:0]      muxZero;
	logic [MuxRegDestWidth-1:0]   muxRegDest;
	logic [MuxWriteDataWidth-1:0] muxWriteData;
	aluOp                         aluControl;
	logic                         memWrite;
	logic                         loadRegAlu;
	logic                         loadRegA;
	logic                         loadRegB;
	logic                         loadRegMemData;
	logic                         loadRegEpc;
	logic                         irWrite;
	logic                         pcWrite;
	logic                         pcWriteCond;
	logic                         regWrite;
	ctrlState                     state;

	ctrlState    mState;
	excCause     mCause;
	instrClass   expCls;
	aluOp        expAlu;
	logic        trapEnable;
	logic [1:0]  expZero;
	logic [31:0] rngState;
	int          testErrors;
	int          totalErrors;
	int          testsPassed;
	int          testsFailed;

	controlUnit controlUnit_i (
		.Clk            (Clk),
		.Reset          (Reset),
		.opcode         (opcode),
		.funct          (funct),
		.instrLow       (instrLow),
		.overflow       (overflow),
		.muxA           (muxA),
		.muxB           (muxB),
		.muxAlu         (muxAlu),
		.muxPc          (muxPc),
		.muxZero        (muxZero),
		.muxRegDest     (muxRegDest),
		.muxWriteData   (muxWriteData),
		.aluControl     (aluControl),
		.memWrite       (memWrite),
		.loadRegAlu     (loadRegAlu),
		.loadRegA       (loadRegA),
		.loadRegB       (loadRegB),
		.loadRegMemData (loadRegMemData),
		.loadRegEpc     (loadRegEpc),
		.irWrite        (irWrite),
		.pcWrite        (pcWrite),
		.pcWriteCond    (pcWriteCond),
		.regWrite       (regWrite),
		.state          (state)
	);

	initial begin
		Clk = 1'b0;
		forever #10 Clk = ~Clk;
	end

	function automatic logic [31:0] nextRandom();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	function automatic bit isKnownOpcode(input logic [OpcodeWidth-1:0] op);
		return op inside {OpRType, OpJump, OpJal, OpBeq, OpBne, OpAddi, OpAddiu, OpLw, OpSw};
	endfunction

	// Prefix is Fetch, FetchWait and Decode, the last cycle is back in Idle
	function automatic int pathLength(input int kind, input bit trapped);
		case (kind)
			KAdd, KSub, KAnd, KAddi, KAddiu: return trapped ? 3 + 5 + 1 : 3 + 3 + 1;
			KBeq, KBne, KJal: return 3 + 2 + 1;
			KLw:              return 3 + 5 + 1;
			KSw:              return 3 + 3 + 1;
			KJ, KJr:          return 3 + 1 + 1;
			KNop:             return 3 + 1;
			default:          return 3 + 3 + 1; // Exc1 to Exc3
		endcase
	endfunction

	task automatic reportMismatch(input string test, input string signal,
			input logic [31:0] expected, input logic [31:0] actual);
		$display("ERR %s %s: expected %0h, actual %0h", test, signal, expected, actual);
		testErrors++;
	endtask

	task automatic checkCycle(input string test);
		modelOutputs want;
		want = modelExpect(mState, expAlu, mCause);
		if (state !== mState)
			reportMismatch(test, "state", 32'(mState), 32'(state));
		if (regWrite !== want.regWrite)
			reportMismatch(test, "regWrite", 32'(want.regWrite), 32'(regWrite));
		if (memWrite !== want.memWrite)
			reportMismatch(test, "memWrite", 32'(want.memWrite), 32'(memWrite));
		if (pcWrite !== want.pcWrite)
			reportMismatch(test, "pcWrite", 32'(want.pcWrite), 32'(pcWrite));
		if (pcWriteCond !== want.pcWriteCond)
			reportMismatch(test, "pcWriteCond", 32'(want.pcWriteCond), 32'(pcWriteCond));
		if (loadRegEpc !== want.loadRegEpc)
			reportMismatch(test, "loadRegEpc", 32'(want.loadRegEpc), 32'(loadRegEpc));
		if (muxPc !== want.muxPc)
			reportMismatch(test, "muxPc", 32'(want.muxPc), 32'(muxPc));
		if (aluControl !== want.aluControl)
			reportMismatch(test, "aluControl", 32'(want.aluControl), 32'(aluControl));
		if ((mState == Branch1 || mState == Branch2) && muxZero !== expZero)
			reportMismatch(test, "muxZero", 32'(expZero), 32'(muxZero));
	endtask

	task automatic checkResetOutputs(input string test);
		logic [8:0] others;
		logic [6:0] dataSels;
		others = {memWrite, loadRegAlu, loadRegA, loadRegB, loadRegMemData, loadRegEpc,
			irWrite, pcWrite, pcWriteCond};
		dataSels = {muxA, muxB, muxAlu};
		if (others !== '0)
			reportMismatch(test, "strobes besides regWrite", 32'd0, 32'(others));
		if (dataSels !== '0)
			reportMismatch(test, "muxA, muxB and muxAlu", 32'd0, 32'(dataSels));
		if (regWrite !== 1'b1)
			reportMismatch(test, "regWrite", 32'd1, 32'(regWrite));
		if (muxRegDest !== 2'd3)
			reportMismatch(test, "muxRegDest", 32'd3, 32'(muxRegDest));
		if (muxWriteData !== 4'd11)
			reportMismatch(test, "muxWriteData", 32'd11, 32'(muxWriteData));
	endtask

	// Model state for the next clock edge, from inputs as they stand now
	task automatic advanceModel();
		logic trapOvf;
		trapOvf = overflow && trapEnable;
		mCause = modelCause(mState, expCls, trapOvf, mCause);
		mState = modelNext(mState, expCls, trapOvf);
	endtask

	task automatic tick(input string test);
		@(negedge Clk);
		checkCycle(test);
	endtask

	task automatic applyReset(input string test);
		Reset = 1'b1;
		mState = ResetSt;
		mCause = CauseOpcode;
		repeat (2) begin
			tick(test);
			checkResetOutputs(test);
		end
		Reset = 1'b0;
		advanceModel();
		tick(test);
		if (state !== Idle)
			reportMismatch(test, "state after reset", 32'(Idle), 32'(state));
	endtask

	task automatic setInstr(input int kind, input logic ovf);
		logic [31:0] r;
		int          tries;
		r = nextRandom();
		opcode = OpRType;
		funct = 6'h00;
		instrLow = r[25:0];
		overflow = ovf;
		trapEnable = 1'b1;
		expAlu = AluNone;
		expZero = 2'd0;
		case (kind)
			KAdd, KSub, KAnd: begin
				funct = (kind == KAdd) ? FnAdd : (kind == KSub) ? FnSub : FnAnd;
				expAlu = (kind == KAdd) ? AluAdd : (kind == KSub) ? AluSub : AluAnd;
				expCls = ClsArith;
			end
			KAddi, KAddiu: begin
				opcode = (kind == KAddi) ? OpAddi : OpAddiu;
				expCls = ClsArithImm;
				expAlu = AluAdd;
				trapEnable = (kind == KAddi); // ADDIU ignores overflow
			end
			KBeq, KBne: begin
				opcode = (kind == KBeq) ? OpBeq : OpBne;
				expCls = (kind == KBeq) ? ClsBeq : ClsBne;
				expAlu = AluAdd;
				expZero = (kind == KBne) ? 2'd1 : 2'd0;
			end
			KLw, KSw: begin
				opcode = (kind == KLw) ? OpLw : OpSw;
				expCls = (kind == KLw) ? ClsLoad : ClsStore;
				expAlu = AluAdd;
			end
			KJ, KJal: begin
				opcode = (kind == KJ) ? OpJump : OpJal;
				expCls = (kind == KJ) ? ClsJump : ClsJal;
			end
			KJr: begin
				funct = FnJr;
				expCls = ClsJumpReg;
			end
			KNop: begin
				instrLow = '0;
				expCls = ClsNop;
			end
			KBreak: begin
				funct = FnBreak;
				expCls = ClsBreak;
			end
			default: begin
				tries = 0;
				opcode = r[31:26];
				while (isKnownOpcode(opcode) && tries < 16) begin
					r = nextRandom();
					opcode = r[31:26];
					tries++;
				end
				if (isKnownOpcode(opcode))
					opcode = 6'h3f;
				expCls = ClsInvalid;
				expAlu = AluUndef;
			end
		endcase
	endtask

	// Starts with the DUT in Idle and returns once it is back there
	task automatic runInstr(input string test, input int kind, input logic ovf);
		int cycles;
		int regWrites;
		int memWrites;
		bit sawExc;
		bit trapped;
		bit wantRegWrite;
		trapped = ovf && (kind inside {KAdd, KSub, KAnd, KAddi});
		wantRegWrite = !trapped && (kind inside {KAdd, KSub, KAnd, KAddi, KAddiu, KLw, KJal});
		setInstr(kind, ovf);
		cycles = 0;
		regWrites = 0;
		memWrites = 0;
		sawExc = 1'b0;
		do begin
			advanceModel();
			tick(test);
			cycles++;
			if (regWrite)
				regWrites++;
			if (memWrite)
				memWrites++;
			if (state == Exc1)
				sawExc = 1'b1;
			if (cycles >= IdleTimeout && state != Idle) begin
				$display("Timeout in %s: DUT did not return to Idle within %0d cycles",
					test, IdleTimeout);
				$display("Test failures found");
				$finish;
			end
		end while (state != Idle);
		if (cycles != pathLength(kind, trapped))
			reportMismatch(test, "cycles to Idle", 32'(pathLength(kind, trapped)), 32'(cycles));
		if (regWrites != int'(wantRegWrite))
			reportMismatch(test, "regWrite count", 32'(wantRegWrite), 32'(regWrites));
		if (memWrites != int'(kind == KSw))
			reportMismatch(test, "memWrite count", 32'(kind == KSw), 32'(memWrites));
		if (sawExc != (trapped || kind == KInvalid))
			reportMismatch(test, "Exc1 entered", 32'(trapped || kind == KInvalid), 32'(sawExc));
	endtask

	task automatic runBreak(input string test);
		int cycles;
		setInstr(KBreak, 1'b0);
		cycles = 0;
		do begin
			advanceModel();
			tick(test);
			cycles++;
			if (cycles >= IdleTimeout && state != Break) begin
				$display("Timeout in %s: DUT did not reach Break within %0d cycles",
					test, IdleTimeout);
				$display("Test failures found");
				$finish;
			end
		end while (state != Break);
		repeat (BreakHold) begin
			advanceModel();
			tick(test); // Model stays in Break too
		end
	endtask

	task automatic finishTest(input string test);
		if (testErrors == 0) begin
			$display("PASS %s", test);
			testsPassed++;
		end else begin
			$display("FAIL %s with %0d errors", test, testErrors);
			testsFailed++;
		end
		totalErrors += testErrors;
		testErrors = 0;
	endtask

	initial begin
		logic [31:0] r;
		int          kind;
		Reset = 1'b1;
		opcode = '0;
		funct = '0;
		instrLow = '0;
		overflow = 1'b0;
		rngState = 32'd13;
		mState = ResetSt;
		mCause = CauseOpcode;
		expCls = ClsNop;
		expAlu = AluNone;
		trapEnable = 1'b1;
		expZero = 2'd0;
		testErrors = 0;
		totalErrors = 0;
		testsPassed = 0;
		testsFailed = 0;

		applyReset("reset");
		finishTest("reset");

		for (int i = 0; i < 12; i++) begin
			r = nextRandom();
			kind = int'(r % 32'd3); // ADD, SUB or AND
			runInstr("arith", kind, 1'b0);
		end
		finishTest("arith");

		for (int i = 0; i < 6; i++) begin
			kind = (i % 3 == 0) ? KAdd : (i % 3 == 1) ? KAddi : KAddiu;
			runInstr("overflow", kind, 1'b1);
		end
		finishTest("overflow");

		for (int i = 0; i < 8; i++) begin
			r = nextRandom();
			runInstr("loadStore", r[4] ? KLw : KSw, 1'b0);
		end
		finishTest("loadStore");

		for (int i = 0; i < 12; i++) begin
			r = nextRandom();
			kind = KBeq + int'(r % 32'd5); // BEQ through JR, except LW and SW
			if (kind == KLw || kind == KSw)
				kind = kind + 3;
			runInstr("branchJump", kind, 1'b0);
		end
		finishTest("branchJump");

		for (int i = 0; i < 4; i++)
			runInstr("invalidNopBreak", KInvalid, 1'b0);
		for (int i = 0; i < 3; i++)
			runInstr("invalidNopBreak", KNop, 1'b0);
		runBreak("invalidNopBreak");
		applyReset("invalidNopBreak");
		finishTest("invalidNopBreak");

		for (int i = 0; i < 40; i++) begin
			r = nextRandom();
			kind = int'(r % 32'd14);
			if (kind == KBreak)
				kind = KInvalid;
			runInstr("randomMix", kind, r[8]);
		end
		finishTest("randomMix");

		$display("Tests: %0d passed, %0d failed, %0d check errors",
			testsPassed, testsFailed, totalErrors);
		if (totalErrors == 0 && testsFailed == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
	input  logic [controlPkg::OpcodeWidth-1:0]   opcode,
	input  logic [controlPkg::FunctWidth-1:0]    funct,
	input  logic [controlPkg::InstrLowWidth-1:0] instrLow,
	output controlPkg::instrClass                cls,
	output controlPkg::aluOp                     aluSel,
	output logic                                 trapOverflow
);
	import controlPkg::*;

	assign trapOverflow = (opcode != OpAddiu); // ADDIU never traps

	always_comb begin
		cls = ClsInvalid;
		aluSel = AluUndef;
		case (opcode)
			OpRType: begin
				case (funct)
					FnAdd: begin
						cls = ClsArith;
						aluSel = AluAdd;
					end
					FnSub: begin
						cls = ClsArith;
						aluSel = AluSub;
					end
					FnAnd: begin
						cls = ClsArith;
						aluSel = AluAnd;
					end
					FnJr: begin
						cls = ClsJumpReg;
						aluSel = AluNone;
					end
					FnBreak: begin
						cls = ClsBreak;
						aluSel = AluNone;
					end
					'0: begin
						if (instrLow == '0) begin // All-zero word is NOP, else SLL
							cls = ClsNop;
							aluSel = AluNone;
						end
					end
					default: ; // Shifts, MULT and DIV land here
				endcase
			end
			OpJump, OpJal: begin
				cls = (opcode == OpJal) ? ClsJal : ClsJump;
				aluSel = AluNone;
			end
			OpBeq, OpBne: begin
				cls = (opcode == OpBne) ? ClsBne : ClsBeq;
				aluSel = AluAdd; // Branch target
			end
			OpAddi, OpAddiu: begin
				cls = ClsArithImm;
				aluSel = AluAdd;
			end
			OpLw, OpSw: begin
				cls = (opcode == OpSw) ? ClsStore : ClsLoad;
				aluSel = AluAdd; // Effective address
			end
			default: ;
		endcase
	end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module controlUnitTb -o controlUnitSim
./obj_dir/controlUnitSim | tee sim.log

if grep -q "All tests passed!" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

//--- stateSequencer.sv
`timescale 1ns/1ps

module stateSequencer (
	input  logic                  Clk,
	input  logic                  Reset,
	input  controlPkg::instrClass cls,
	input  logic                  trapOverflow,
	input  logic                  overflow,
	output controlPkg::ctrlState  state,
	output controlPkg::excCause   cause
);
	import controlPkg::*;

	ctrlState nextState;
	logic     trapNow;

	// Overflow only counts in the ALU result cycle
	assign trapNow = overflow && trapOverflow && (state == Arith2 || state == ArithImm2);

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			state <= ResetSt;
			cause <= CauseOpcode;
		end else begin
			state <= nextState;
			if (trapNow)
				cause <= CauseOverflow;
			else if (state == Decode && cls == ClsInvalid)
				cause <= CauseOpcode;
		end
	end

	always_comb begin
		nextState = Idle;
		case (state)
			Idle:      nextState = Fetch;
			Fetch:     nextState = FetchWait;
			FetchWait: nextState = Decode;
			Decode: begin
				case (cls)
					ClsNop:      nextState = Idle;
					ClsArith:    nextState = Arith1;
					ClsArithImm: nextState = ArithImm1;
					ClsBeq:      nextState = Branch1;
					ClsBne:      nextState = Branch1;
					ClsLoad:     nextState = Load1;
					ClsStore:    nextState = Store1;
					ClsJump:     nextState = Jump;
					ClsJal:      nextState = Jal;
					ClsJumpReg:  nextState = JumpReg;
					ClsBreak:    nextState = Break;
					default:     nextState = Exc1; // Unknown opcode or funct
				endcase
			end
			Arith1:    nextState = Arith2;
			Arith2:    nextState = trapNow ? Exc1 : Arith3;
			Arith3:    nextState = Idle;
			ArithImm1: nextState = ArithImm2;
			ArithImm2: nextState = trapNow ? Exc1 : ArithImm3;
			ArithImm3: nextState = Idle;
			Branch1:   nextState = Branch2;
			Branch2:   nextState = Idle;
			Load1:     nextState = Load2;
			Load2:     nextState = LoadWait;
			LoadWait:  nextState = Load3; // Memory read latency
			Load3:     nextState = Load4;
			Load4:     nextState = Idle;
			Store1:    nextState = Store2;
			Store2:    nextState = Store3;
			Store3:    nextState = Idle;
			Jal:       nextState = Jump; // Link first, then jump
			Jump:      nextState = Idle;
			JumpReg:   nextState = Idle;
			Break:     nextState = Break; // Only Reset leaves
			Exc1:      nextState = Exc2;
			Exc2:      nextState = Exc3;
			Exc3:      nextState = Idle;
			ResetSt:   nextState = Idle;
			default:   nextState = Idle;
		endcase
	end

	// Enum is dense with ResetSt as its last member
	assert property (@(posedge Clk) disable iff (Reset)
		!$isunknown(state) && state <= ResetSt)
		else $error("state register holds illegal value %0d", state);

	assert property (@(posedge Clk) disable iff (Reset)
		state == Break |=> state == Break)
		else $error("left Break without a reset");

endmodule

//--- verilog.f
+incdir+.
controlPkg.sv
instrDecoder.sv
stateSequencer.sv
controlEncoder.sv
controlUnit.sv
controlUnitTb.sv
